// File: rv64Core.f
+incdir+.
rv64Pkg.sv
rv64ImmGen.sv
rv64Decoder.sv
rv64Alu.sv
rv64RegFile.sv
rv64Csr.sv
rv64Core.sv
rv64Core_checker.sv
rv64Core_tb.sv

// File: rv64Core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64Core_tb import rv64Pkg::*; ();

    localparam int PERIOD = 40;

    logic             clk;
    logic             arstN;
    logic [`XLEN-1:0] instAddr;
    logic [31:0]      inst;
    logic [`XLEN-1:0] dataAddr;
    logic [`XLEN-1:0] dataRdata;
    logic [`XLEN-1:0] dataWdata;
    logic [7:0]       dataWmask;
    logic             halt;

    logic [31:0]      imem [256];
    logic [63:0]      dmem [128];
    int               seed = 27582;
    int               progPc;
    int               progLen;
    int               resOff;
    bit               progReady;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [63:0]      r0;
    string            expName [$];
    logic [63:0]      expAddr [$];
    logic [63:0]      expData [$];
    logic [7:0]       expMask [$];
    string            curName;
    logic [63:0]      curBits;

    rv64Core u_rv64Core (
        .clk(clk), .arstN(arstN), .instAddr(instAddr), .inst(inst),
        .dataAddr(dataAddr), .dataRdata(dataRdata), .dataWdata(dataWdata),
        .dataWmask(dataWmask), .halt(halt)
    );

    assign inst      = imem[instAddr[9:2]];
    assign dataRdata = dmem[dataAddr[9:3]];

    always @(posedge clk) begin
        if (arstN) begin
            for (int i = 0; i < 8; i++) begin
                if (dataWmask[i]) dmem[dataAddr[9:3]][i*8 +: 8] <= dataWdata[i*8 +: 8];
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            abortRun("value mismatch");
        end
    endtask

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] lanesToBits(input logic [7:0] m);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) r[i*8 +: 8] = {8{m[i]}};
        return r;
    endfunction

    function automatic logic [63:0] divwRef(input logic [31:0] x, input logic [31:0] y,
                                            input bit rem);
        logic signed [31:0] sx;
        logic signed [31:0] sy;
        sx = x;
        sy = y;
        if (sy == 0) return rem ? sext32(sx) : '1;
        if (sx == 32'h8000_0000 && sy == -1) return rem ? 64'd0 : sext32(sx); // overflow case
        return rem ? sext32(sx % sy) : sext32(sx / sy);
    endfunction

    function automatic logic [63:0] divuwRef(input logic [31:0] x, input logic [31:0] y,
                                             input bit rem);
        if (y == 0) return rem ? sext32(x) : '1;
        return rem ? sext32(x % y) : sext32(x / y);
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[progPc >> 2] = w;
        progPc += 4;
        progLen++;
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic expectStore(input string name, input logic [63:0] addr,
                               input logic [63:0] data, input logic [7:0] mask);
        expName.push_back(name);
        expAddr.push_back(addr);
        expData.push_back(data);
        expMask.push_back(mask);
    endtask

    // sd rs into the next result slot at 0x200
    task automatic storeResult(input logic [4:0] rs, input string name, input logic [63:0] v);
        emit(encS(12'(resOff), rs, 5'd11, 3'b011));
        expectStore(name, 64'h200 + resOff, v, 8'hff);
        resOff += 8;
    endtask

    task automatic aluTest(input string name, input logic [6:0] f7, input logic [2:0] f3,
                           input logic [6:0] op, input logic [4:0] rs2, input logic [63:0] v);
        emit(encR(f7, rs2, 5'd1, f3, 5'd3, op));
        storeResult(5'd3, name, v);
    endtask

    task automatic loadTest(input string name, input logic [2:0] f3, input logic [11:0] off,
                            input logic [63:0] v);
        emit(encI(off, 5'd10, f3, 5'd3, OPC_LOAD));
        storeResult(5'd3, name, v);
    endtask

    // taken path writes 0x22, fall-through writes 0x11
    task automatic branchTest(input string name, input logic [2:0] f3, input logic [4:0] rs2,
                              input bit taken);
        emit(encB(13'd12, rs2, 5'd1, f3));
        emit(encI(12'h011, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        emit(encJ(21'd8, 5'd0));
        emit(encI(12'h022, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        storeResult(5'd6, name, taken ? 64'h22 : 64'h11);
    endtask

    task automatic buildProgram();
        int ecallPc;
        int p;
        for (int i = 0; i < 256; i++) imem[i] = encI(12'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
        for (int i = 0; i < 128; i++) dmem[i] = {$random(seed), $random(seed)};
        a  = dmem[32];
        b  = dmem[33];
        r0 = a;
        emit(encS(12'h3f0, 5'd0, 5'd0, 3'b011)); // already fetched while in reset
        expectStore("first store", 64'h3f0, 64'd0, 8'hff);
        emit(encI(12'h100, 5'd0, 3'b000, 5'd10, OPC_OP_IMM)); // operand base
        emit(encI(12'h200, 5'd0, 3'b000, 5'd11, OPC_OP_IMM)); // result base
        emit(encI(12'd0, 5'd10, 3'b011, 5'd1, OPC_LOAD));
        emit(encI(12'd8, 5'd10, 3'b011, 5'd2, OPC_LOAD));
        aluTest("add", 7'h00, 3'b000, OPC_OP, 5'd2, a + b);
        aluTest("sub", 7'h20, 3'b000, OPC_OP, 5'd2, a - b);
        aluTest("and", 7'h00, 3'b111, OPC_OP, 5'd2, a & b);
        aluTest("or", 7'h00, 3'b110, OPC_OP, 5'd2, a | b);
        aluTest("xor", 7'h00, 3'b100, OPC_OP, 5'd2, a ^ b);
        aluTest("sll", 7'h00, 3'b001, OPC_OP, 5'd2, a << b[5:0]);
        aluTest("srl", 7'h00, 3'b101, OPC_OP, 5'd2, a >> b[5:0]);
        aluTest("sra", 7'h20, 3'b101, OPC_OP, 5'd2, $signed(a) >>> b[5:0]);
        aluTest("slt", 7'h00, 3'b010, OPC_OP, 5'd2, {63'd0, $signed(a) < $signed(b)});
        aluTest("sltu", 7'h00, 3'b011, OPC_OP, 5'd2, {63'd0, a < b});
        aluTest("mul", 7'h01, 3'b000, OPC_OP, 5'd2, a * b);
        aluTest("addw", 7'h00, 3'b000, OPC_OP_32, 5'd2, sext32(a[31:0] + b[31:0]));
        aluTest("subw", 7'h20, 3'b000, OPC_OP_32, 5'd2, sext32(a[31:0] - b[31:0]));
        aluTest("mulw", 7'h01, 3'b000, OPC_OP_32, 5'd2, sext32(a[31:0] * b[31:0]));
        aluTest("srlw", 7'h00, 3'b101, OPC_OP_32, 5'd2, sext32(a[31:0] >> b[4:0]));
        aluTest("sraw", 7'h20, 3'b101, OPC_OP_32, 5'd2,
                sext32($signed(a[31:0]) >>> b[4:0]));
        aluTest("divw", 7'h01, 3'b100, OPC_OP_32, 5'd2, divwRef(a[31:0], b[31:0], 1'b0));
        aluTest("divw by zero", 7'h01, 3'b100, OPC_OP_32, 5'd0,
                divwRef(a[31:0], 32'd0, 1'b0));
        aluTest("remw", 7'h01, 3'b110, OPC_OP_32, 5'd2, divwRef(a[31:0], b[31:0], 1'b1));
        aluTest("divuw", 7'h01, 3'b101, OPC_OP_32, 5'd2, divuwRef(a[31:0], b[31:0], 1'b0));
        aluTest("remuw", 7'h01, 3'b111, OPC_OP_32, 5'd2, divuwRef(a[31:0], b[31:0], 1'b1));
        emit(encI(12'hffb, 5'd1, 3'b000, 5'd3, OPC_OP_IMM));
        storeResult(5'd3, "addi", a - 64'd5);
        loadTest("lb", 3'b000, 12'd3, {{56{r0[31]}}, r0[31:24]});
        loadTest("lbu", 3'b100, 12'd5, {56'd0, r0[47:40]});
        loadTest("lh", 3'b001, 12'd2, {{48{r0[31]}}, r0[31:16]});
        loadTest("lhu", 3'b101, 12'd6, {48'd0, r0[63:48]});
        loadTest("lw", 3'b010, 12'd4, sext32(r0[63:32]));
        loadTest("ld", 3'b011, 12'd0, r0);
        emit(encI(12'h3c0, 5'd0, 3'b000, 5'd12, OPC_OP_IMM));
        emit(encS(12'd1, 5'd2, 5'd12, 3'b000));
        expectStore("sb lane", 64'h3c1, b << 8, 8'h02);
        emit(encS(12'd6, 5'd2, 5'd12, 3'b001));
        expectStore("sh lane", 64'h3c6, b << 48, 8'hc0);
        emit(encS(12'd4, 5'd2, 5'd12, 3'b010));
        expectStore("sw lane", 64'h3c4, b << 32, 8'hf0);
        branchTest("beq", 3'b000, 5'd1, 1'b1);
        branchTest("bne", 3'b001, 5'd2, a != b);
        branchTest("blt", 3'b100, 5'd2, $signed(a) < $signed(b));
        branchTest("bge", 3'b101, 5'd2, $signed(a) >= $signed(b));
        branchTest("bltu", 3'b110, 5'd2, a < b);
        branchTest("bgeu", 3'b111, 5'd2, a >= b);
        p = progPc;
        emit(encJ(21'd8, 5'd7));
        emit(encI(12'd0, 5'd0, 3'b000, 5'd7, OPC_OP_IMM)); // skipped
        storeResult(5'd7, "jal link", 64'(p + 4));
        p = progPc;
        emit({20'd0, 5'd9, OPC_AUIPC});
        emit(encI(12'd17, 5'd9, 3'b000, 5'd9, OPC_OP_IMM)); // odd target so bit 0 gets dropped
        emit(encI(12'd0, 5'd9, 3'b000, 5'd13, OPC_JALR));
        emit(encI(12'd0, 5'd0, 3'b000, 5'd13, OPC_OP_IMM)); // skipped
        storeResult(5'd13, "jalr link", 64'(p + 12));
        emit(encI(12'h300, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        emit(encI(12'h305, 5'd14, 3'b001, 5'd0, OPC_SYSTEM));
        ecallPc = progPc;
        emit(encI(12'h000, 5'd0, 3'b000, 5'd0, OPC_SYSTEM));
        progPc = 'h300; // trap handler
        emit(encI(12'h341, 5'd0, 3'b010, 5'd15, OPC_SYSTEM));
        storeResult(5'd15, "mepc", 64'(ecallPc));
        emit(encI(12'h342, 5'd0, 3'b010, 5'd16, OPC_SYSTEM));
        storeResult(5'd16, "mcause", 64'd11);
        emit(encI(12'd4, 5'd15, 3'b000, 5'd15, OPC_OP_IMM));
        emit(encI(12'h341, 5'd15, 3'b001, 5'd0, OPC_SYSTEM));
        emit(encI(12'h302, 5'd0, 3'b000, 5'd0, OPC_SYSTEM)); // mret
        progPc = ecallPc + 4;
        emit(encI(12'h055, 5'd0, 3'b000, 5'd17, OPC_OP_IMM));
        storeResult(5'd17, "after mret", 64'h55);
        emit(encI(12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM)); // ebreak
        emit(encS(12'h1f8, 5'd17, 5'd11, 3'b011)); // must never run
    endtask

    // every store is matched against the next expected one
    always @(negedge clk) begin
        if (arstN && dataWmask != 8'h00) begin
            if (expAddr.size() == 0) begin
                abortRun("a store appeared where none was expected");
            end else begin
                curName = expName.pop_front();
                curBits = lanesToBits(expMask[0]);
                checkEqual({curName, " addr"}, expAddr.pop_front(), dataAddr);
                checkEqual({curName, " mask"}, {56'd0, expMask.pop_front()},
                           {56'd0, dataWmask});
                checkEqual({curName, " data"}, expData.pop_front() & curBits,
                           dataWdata & curBits);
            end
        end
    end

    always @(u_rv64Core.u_rv64Core_checker.failCount) begin
        if (u_rv64Core.u_rv64Core_checker.failCount != 0) begin
            abortRun("a port assertion in the bound checker failed");
        end
    end

    initial begin
        wait (progReady);
        #((progLen + 400) * PERIOD);
        abortRun("watchdog expired before the program reached ebreak");
    end

    initial begin
        arstN   = 1'b0;
        progPc  = 0;
        progLen = 0;
        resOff  = 0;
        buildProgram();
        progReady = 1'b1;
        repeat (8) @(posedge clk);
        #2 arstN = 1'b1;
        @(negedge clk);
        checkEqual("reset pc", `RESET_PC, instAddr);
        wait (halt === 1'b1);
        repeat (5) @(negedge clk);
        if (expAddr.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("halt reached with %0d expected stores missing", expAddr.size());
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: rv64Core_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64Core_checker (
    input logic             clk,
    input logic             arstN,
    input logic [`XLEN-1:0] instAddr,
    input logic [7:0]       dataWmask,
    input logic             halt
);

    int unsigned failCount = 0;

    // outputs quiet while in reset
    resetQuiet: assert property (@(posedge clk) !arstN |-> (dataWmask == 8'h00) && !halt)
        else begin
            failCount++;
            $error("dataWmask or halt active during reset");
        end

    fetchAligned: assert property (@(posedge clk) disable iff (!arstN)
        instAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instAddr not word aligned");
        end

    // pc frozen once halted
    haltFreeze: assert property (@(posedge clk) disable iff (!arstN)
        halt |=> $stable(instAddr))
        else begin
            failCount++;
            $error("instAddr moved after halt");
        end

endmodule

bind rv64Core rv64Core_checker u_rv64Core_checker (
    .clk(clk),
    .arstN(arstN),
    .instAddr(instAddr),
    .dataWmask(dataWmask),
    .halt(halt)
);

`default_nettype wire

// File: rv64Core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64Core import rv64Pkg::*; (
    input  logic             clk,
    input  logic             arstN,
    output logic [`XLEN-1:0] instAddr,
    input  logic [31:0]      inst,
    output logic [`XLEN-1:0] dataAddr,
    input  logic [`XLEN-1:0] dataRdata,
    output logic [`XLEN-1:0] dataWdata,
    output logic [7:0]       dataWmask,
    output logic             halt
);

    logic [`XLEN-1:0] pc, pcPlus4, nextPc, target;
    logic [`XLEN-1:0] imm, rs1Data, rs2Data, csrRdata, mtvec, mepc;
    logic [`XLEN-1:0] aluA, aluB, aluResult, loadShift, loadData, wbData;
    logic [7:0]       laneMask;
    aluOpE            aluOp;
    selAE             selA;
    selBE             selB;
    wbSelE            wbSel;
    logic             regWen, csrWen, takeTarget, targetFromRs1;
    logic             trapEnter, trapReturn, opWord, loadSigned, isEbreak;
    logic [3:0]       readBytes, storeBytes;

    rv64Decoder u_rv64Decoder (
        .inst(inst), .imm(imm), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluOp(aluOp), .selA(selA), .selB(selB), .wbSel(wbSel),
        .regWen(regWen), .csrWen(csrWen), .takeTarget(takeTarget),
        .targetFromRs1(targetFromRs1), .trapEnter(trapEnter), .trapReturn(trapReturn),
        .opWord(opWord), .loadSigned(loadSigned), .isEbreak(isEbreak),
        .readBytes(readBytes), .storeBytes(storeBytes)
    );

    rv64ImmGen u_rv64ImmGen (.inst(inst), .imm(imm));

    rv64RegFile u_rv64RegFile (
        .clk(clk), .arstN(arstN),
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]), .rdAddr(inst[11:7]),
        .wen(regWen && !halt), .wdata(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    rv64Csr u_rv64Csr (
        .clk(clk), .arstN(arstN), .csrAddr(imm[11:0]),
        .csrWen(csrWen && !halt), .csrWdata(aluResult),
        .trapEnter(trapEnter && !halt), .trapPc(pc),
        .csrRdata(csrRdata), .mtvec(mtvec), .mepc(mepc)
    );

    assign aluA = (selA == SELA_PC) ? pc : rs1Data;
    assign aluB = (selB == SELB_RS2) ? rs2Data : (selB == SELB_CSR) ? csrRdata : imm;

    rv64Alu u_rv64Alu (.a(aluA), .b(aluB), .op(aluOp), .opWord(opWord), .result(aluResult));

    // next pc
    assign pcPlus4 = pc + `XLEN'd4;
    assign target  = targetFromRs1 ? {aluResult[`XLEN-1:1], 1'b0} : aluResult;
    assign nextPc  = trapEnter  ? mtvec :
                     trapReturn ? mepc  :
                     takeTarget ? target : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc   <= `RESET_PC;
            halt <= 1'b0;
        end else begin
            if (isEbreak) begin
                halt <= 1'b1;
            end
            if (!halt && !isEbreak) begin // freeze on ebreak
                pc <= nextPc;
            end
        end
    end

    assign instAddr = pc;
    assign dataAddr = aluResult;

    // load lane extraction
    assign loadShift = dataRdata >> {dataAddr[2:0], 3'b000};
    always_comb begin
        case (readBytes)
            4'd1:    loadData = {{(`XLEN-8){loadSigned & loadShift[7]}}, loadShift[7:0]};
            4'd2:    loadData = {{(`XLEN-16){loadSigned & loadShift[15]}}, loadShift[15:0]};
            4'd4:    loadData = {{(`XLEN-32){loadSigned & loadShift[31]}}, loadShift[31:0]};
            default: loadData = loadShift;
        endcase
    end

    // store lanes
    assign laneMask  = 8'((16'd1 << storeBytes) - 16'd1);
    assign dataWdata = rs2Data << {dataAddr[2:0], 3'b000};
    assign dataWmask = (!arstN || halt) ? 8'h00 : 8'(laneMask << dataAddr[2:0]);

    always_comb begin
        case (wbSel)
            WB_MEM:   wbData = loadData;
            WB_PC4:   wbData = pcPlus4;
            WB_ALU_W: wbData = {{(`XLEN-32){aluResult[31]}}, aluResult[31:0]};
            WB_CSR:   wbData = csrRdata; // old csr value
            default:  wbData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// File: rv64Csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64Csr (
    input  logic             clk,
    input  logic             arstN,
    input  logic [11:0]      csrAddr,
    input  logic             csrWen,
    input  logic [`XLEN-1:0] csrWdata,
    input  logic             trapEnter,
    input  logic [`XLEN-1:0] trapPc,
    output logic [`XLEN-1:0] csrRdata,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc
);

    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MTVEC   = 12'h305;
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
    localparam int          MIE          = 3;
    localparam int          MPIE         = 7;

    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mstatus;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= '0;
        end else if (trapEnter) begin
            mepc          <= trapPc;
            mcause        <= `XLEN'd11; // ecall from M-mode
            mstatus[MPIE] <= mstatus[MIE];
            mstatus[MIE]  <= 1'b0;
        end else if (csrWen) begin
            case (csrAddr)
                ADDR_MSTATUS: mstatus <= csrWdata;
                ADDR_MTVEC:   mtvec   <= csrWdata;
                ADDR_MEPC:    mepc    <= csrWdata;
                ADDR_MCAUSE:  mcause  <= csrWdata;
                default:      mcause  <= mcause; // unknown csr ignored
            endcase
        end
    end

    always_comb begin
        case (csrAddr)
            ADDR_MSTATUS: csrRdata = mstatus;
            ADDR_MTVEC:   csrRdata = mtvec;
            ADDR_MEPC:    csrRdata = mepc;
            ADDR_MCAUSE:  csrRdata = mcause;
            default:      csrRdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rv64RegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64RegFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [$clog2(`NUM_REGS)-1:0] rs1Addr,
    input  logic [$clog2(`NUM_REGS)-1:0] rs2Addr,
    input  logic [$clog2(`NUM_REGS)-1:0] rdAddr,
    input  logic                         wen,
    input  logic [`XLEN-1:0]             wdata,
    output logic [`XLEN-1:0]             rs1Data,
    output logic [`XLEN-1:0]             rs2Data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wen && (rdAddr != '0)) begin // x0 never written
            regs[rdAddr] <= wdata;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: rv64Alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64Alu import rv64Pkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  aluOpE            op,
    input  logic             opWord,
    output logic [`XLEN-1:0] result
);

    localparam int HALF = `XLEN / 2;

    logic                    signedSrc;
    logic [`XLEN-1:0]        opA;
    logic [`XLEN-1:0]        opB;
    logic [5:0]              shamt;
    logic                    divZero;
    logic                    divOvf;
    logic signed [`XLEN-1:0] quotS;
    logic signed [`XLEN-1:0] remS;

    // word ops narrow the sources first
    assign signedSrc = (op == ALU_SRA) || (op == ALU_DIV) || (op == ALU_REM);
    assign opA = !opWord  ? a :
                 signedSrc ? {{HALF{a[HALF-1]}}, a[HALF-1:0]} : {{HALF{1'b0}}, a[HALF-1:0]};
    assign opB = !opWord  ? b :
                 signedSrc ? {{HALF{b[HALF-1]}}, b[HALF-1:0]} : {{HALF{1'b0}}, b[HALF-1:0]};
    assign shamt = opWord ? {1'b0, b[4:0]} : b[5:0];

    assign divZero = (opB == '0);
    assign divOvf  = (opA == {1'b1, {(`XLEN-1){1'b0}}}) && (&opB); // most negative / -1
    assign quotS   = $signed(opA) / $signed(opB);
    assign remS    = $signed(opA) % $signed(opB);

    always_comb begin
        case (op)
            ALU_ADD:      result = opA + opB;
            ALU_SUB:      result = opA - opB;
            ALU_AND:      result = opA & opB;
            ALU_OR:       result = opA | opB;
            ALU_XOR:      result = opA ^ opB;
            ALU_SLL:      result = opA << shamt;
            ALU_SRL:      result = opA >> shamt;
            ALU_SRA:      result = $signed(opA) >>> shamt;
            ALU_SLT:      result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU:     result = {{(`XLEN-1){1'b0}}, opA < opB};
            ALU_MUL:      result = opA * opB;
            ALU_DIV:      result = divZero ? '1 : divOvf ? opA : quotS;
            ALU_DIVU:     result = divZero ? '1 : opA / opB;
            ALU_REM:      result = divZero ? opA : divOvf ? '0 : remS;
            ALU_REMU:     result = divZero ? opA : opA % opB;
            ALU_RETURN_A: result = a;
            ALU_RETURN_B: result = b;
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rv64Decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64Decoder import rv64Pkg::*; (
    input  logic [31:0]      inst,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    output aluOpE            aluOp,
    output selAE             selA,
    output selBE             selB,
    output wbSelE            wbSel,
    output logic             regWen,
    output logic             csrWen,
    output logic             takeTarget,
    output logic             targetFromRs1,
    output logic             trapEnter,
    output logic             trapReturn,
    output logic             opWord,
    output logic             loadSigned,
    output logic             isEbreak,
    output logic [3:0]       readBytes,
    output logic [3:0]       storeBytes
);

    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // integer ops shared by register and immediate forms
    function automatic aluOpE baseOp(input logic [2:0] f3, input logic alt, input logic isReg);
        case (f3)
            3'b000:  return (isReg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic aluOpE mulDivOp(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_MUL;
            3'b100:  return ALU_DIV;
            3'b101:  return ALU_DIVU;
            3'b110:  return ALU_REM;
            3'b111:  return ALU_REMU;
            default: return ALU_NONE; // mulh family not supported
        endcase
    endfunction

    always_comb begin
        aluOp         = ALU_NONE;
        selA          = SELA_RS1;
        selB          = SELB_IMM;
        wbSel         = WB_ALU;
        regWen        = 1'b0;
        csrWen        = 1'b0;
        takeTarget    = 1'b0;
        targetFromRs1 = 1'b0;
        trapEnter     = 1'b0;
        trapReturn    = 1'b0;
        opWord        = 1'b0;
        loadSigned    = 1'b0;
        isEbreak      = 1'b0;
        readBytes     = 4'd0;
        storeBytes    = 4'd0;
        case (opcode)
            OPC_OP, OPC_OP_32: begin
                selB   = SELB_RS2;
                regWen = 1'b1;
                opWord = (opcode == OPC_OP_32);
                wbSel  = opWord ? WB_ALU_W : WB_ALU;
                if (funct7 == 7'b0000001) begin
                    aluOp = mulDivOp(funct3);
                end else begin
                    aluOp = baseOp(funct3, funct7[5], 1'b1);
                end
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                regWen = 1'b1;
                opWord = (opcode == OPC_OP_IMM_32);
                wbSel  = opWord ? WB_ALU_W : WB_ALU;
                aluOp  = baseOp(funct3, funct7[5], 1'b0); // shamt lives in imm
            end
            OPC_LUI: begin
                regWen = 1'b1;
                aluOp  = ALU_RETURN_B;
            end
            OPC_AUIPC: begin
                regWen = 1'b1;
                selA   = SELA_PC;
                aluOp  = ALU_ADD;
            end
            OPC_JAL: begin
                regWen     = 1'b1;
                selA       = SELA_PC;
                aluOp      = ALU_ADD; // pc + imm
                wbSel      = WB_PC4;
                takeTarget = 1'b1;
            end
            OPC_JALR: begin
                regWen        = 1'b1;
                aluOp         = ALU_ADD; // rs1 + imm
                wbSel         = WB_PC4;
                takeTarget    = 1'b1;
                targetFromRs1 = 1'b1;
            end
            OPC_BRANCH: begin
                selA  = SELA_PC;
                aluOp = ALU_ADD;
                case (funct3)
                    3'b000:  takeTarget = (rs1Data == rs2Data);
                    3'b001:  takeTarget = (rs1Data != rs2Data);
                    3'b100:  takeTarget = ($signed(rs1Data) < $signed(rs2Data));
                    3'b101:  takeTarget = ($signed(rs1Data) >= $signed(rs2Data));
                    3'b110:  takeTarget = (rs1Data < rs2Data);
                    3'b111:  takeTarget = (rs1Data >= rs2Data);
                    default: takeTarget = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                regWen     = 1'b1;
                aluOp      = ALU_ADD;
                wbSel      = WB_MEM;
                readBytes  = 4'd1 << funct3[1:0]; // 1, 2, 4 or 8
                loadSigned = !funct3[2];
            end
            OPC_STORE: begin
                aluOp      = ALU_ADD;
                storeBytes = 4'd1 << funct3[1:0];
            end
            OPC_SYSTEM: begin
                case (funct3)
                    3'b001: begin // csrrw
                        regWen = 1'b1;
                        csrWen = 1'b1;
                        wbSel  = WB_CSR;
                        aluOp  = ALU_RETURN_A;
                    end
                    3'b010: begin // csrrs
                        regWen = 1'b1;
                        csrWen = 1'b1;
                        wbSel  = WB_CSR;
                        selB   = SELB_CSR;
                        aluOp  = ALU_OR;
                    end
                    3'b000: begin
                        case (imm[11:0])
                            12'h000: trapEnter  = 1'b1; // ecall
                            12'h001: isEbreak   = 1'b1;
                            12'h302: trapReturn = 1'b1; // mret
                            default: trapEnter  = 1'b0;
                        endcase
                    end
                    default: aluOp = ALU_NONE;
                endcase
            end
            default: aluOp = ALU_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: rv64ImmGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64ImmGen import rv64Pkg::*; (
    input  logic [31:0]       inst,
    output logic [`XLEN-1:0]  imm
);

    opcodeE opcode;

    assign opcode = opcodeE'(inst[6:0]);

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR, OPC_LOAD:
                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            OPC_STORE:
                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH:
                imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            OPC_JAL:
                imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            OPC_SYSTEM:
                imm = {{(`XLEN-12){1'b0}}, inst[31:20]}; // funct12, csr address
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rv64Pkg.sv
`default_nettype none

package rv64Pkg;

    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_SYSTEM    = 7'b1110011
    } opcodeE;

    typedef enum logic [4:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
        ALU_RETURN_A, ALU_RETURN_B
    } aluOpE;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_ALU_W, // low word, sign extended
        WB_CSR
    } wbSelE;

    typedef enum logic [1:0] {
        SELA_PC,
        SELA_RS1
    } selAE;

    typedef enum logic [1:0] {
        SELB_IMM,
        SELB_RS2,
        SELB_CSR
    } selBE;

endpackage

`default_nettype wire

// File: rv64_settings.svh
`ifndef RV64_SETTINGS_SVH
`define RV64_SETTINGS_SVH

// datapath width
`define XLEN 64

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// architectural integer registers
`define NUM_REGS 32

`endif
